//--- sources.f
icache_pkg.sv
mem_dp.sv
icache.sv
prefetch_fill.sv
icache_top.sv
tb_clock_gen.sv
icache_properties.sv
icache_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f sources.f --top-module icache_tb -Mdir obj_dir \
    && ./obj_dir/Vicache_tb \
    || exit 1

//--- icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// random fetch and squash stimulus against a line model
// memory block for block number b is a fixed pattern of b
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_tb;

    import icache_pkg::*;

    localparam int PD    = 4;
    localparam int STEPS = 40;

    logic clock, reset;
    addr_t fetch_addr;
    br_task_t br_task;
    mem_block_t [PD-1:0] data_out;
    logic [PD-1:0] valid_out, alloc_out;
    logic ar_valid, ar_ready, r_valid, r_ready;
    axi_ar_t ar;
    axi_r_t r;

    integer seed = 32'h2013;
    int ar_hs, r_hs;
    // model of the lines, filled block per index
    blk_num_t model_blk [ICACHE_LINES];
    logic model_ok [ICACHE_LINES];
    logic pend, stale;
    blk_num_t pend_blk, req_blk;

    tb_clock_gen clk_gen (.clock(clock), .reset(reset));

    icache_top #(.PREFETCH_DISTANCE(PD)) UUT (
        .clock(clock), .reset(reset), .fetch_addr(fetch_addr), .br_task(br_task),
        .data_out(data_out), .valid_out(valid_out), .alloc_out(alloc_out),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r), .r_ready(r_ready)
    );

    function automatic mem_block_t mem_rule(blk_num_t b);
        return {4{3'b000, b}} ^ 64'ha5c3_0f96_3c5a_e17b;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal;
        end
    endtask

    // lane checks, outputs are settled 1 ns after the edge
    task automatic check_lanes();
        blk_num_t b;
        for (int i = 0; i < PD; i++) begin
            b = fetch_addr[15:3] + blk_num_t'(i);
            check_value($sformatf("valid_out[%0d]", i), valid_out[i],
                model_ok[b[4:0]] && model_blk[b[4:0]] == b);
            if (valid_out[i]) begin
                check_value($sformatf("data_out[%0d]", i), data_out[i], mem_rule(b));
            end
        end
    endtask

    // memory responder
    initial begin
        addr_t a;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            @(posedge clock);
            #1;
            if (!reset && ar_valid) begin
                repeat ($unsigned($random(seed)) % 4) begin
                    @(posedge clock);
                    #1;
                end
                ar_ready = 1'b1;
                a = ar.addr;
                @(posedge clock);
                #1 ar_ready = 1'b0;
                repeat ($unsigned($random(seed)) % 6) begin
                    @(posedge clock);
                    #1;
                end
                r_valid = 1'b1;
                r = '{data: mem_rule(a[15:3]), resp: AXI_RESP_OKAY};
                // hold the response until the master takes it
                while (!r_ready) begin
                    @(posedge clock);
                    #1;
                end
                @(posedge clock);
                #1 r_valid = 1'b0;
            end
        end
    end

    // handshake monitor and model update, fill lands two edges after R
    always @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < ICACHE_LINES; k++) model_ok[k] <= 1'b0;
            pend  <= 1'b0;
            stale <= 1'b0;
            ar_hs <= 0;
            r_hs  <= 0;
        end else begin
            pend <= 1'b0;
            if (pend && br_task != BR_SQUASH) begin
                model_ok[pend_blk[4:0]]  <= 1'b1;
                model_blk[pend_blk[4:0]] <= pend_blk;
            end
            if (ar_valid && ar_ready) begin
                // instruction access, block aligned
                check_value("ar.prot", ar.prot, 3'b100);
                check_value("ar.addr[2:0]", ar.addr[2:0], 3'b000);
                ar_hs   <= ar_hs + 1;
                req_blk <= ar.addr[15:3];
            end
            if (r_valid && r_ready) begin
                r_hs     <= r_hs + 1;
                pend     <= !(stale || br_task == BR_SQUASH);
                pend_blk <= req_blk;
                stale    <= 1'b0;
            end else if (br_task == BR_SQUASH && (ar_valid || r_ready)) begin
                stale <= 1'b1;
            end
        end
    end

    // watchdog
    initial begin
        #(200 * STEPS * 4 + 200);
        $display("watchdog timeout, cache never filled the fetch lanes");
        $display("TB FAILED");
        $fatal;
    end

    initial begin
        addr_t hist [2];
        logic sq;
        fetch_addr = '0;
        br_task    = BR_NONE;
        // first cycle with reset low
        @(negedge reset);
        check_value("valid_out", valid_out, '0);
        check_value("alloc_out", alloc_out, '0);
        check_value("ar_valid", ar_valid, 1'b0);
        for (int s = 0; s < STEPS; s++) begin
            // conflict, return to an old address, or fresh address
            if (s % 3 == 1) begin
                fetch_addr = hist[0] ^ {8'($unsigned($random(seed)) % 255 + 1), 8'h00};
            end else if (s % 3 == 2) begin
                fetch_addr = hist[1];
            end else begin
                fetch_addr = $random(seed);
            end
            hist[1] = hist[0];
            hist[0] = fetch_addr;
            do begin
                sq = ($unsigned($random(seed)) % 12) == 0;
                br_task = sq ? BR_SQUASH : BR_NONE;
                @(posedge clock);
                #1;
                br_task = BR_NONE;
                if (sq) check_value("alloc_out", alloc_out, '0);
                check_lanes();
            end while (valid_out != '1);
        end
        while (ar_valid || r_ready || pend) begin
            @(posedge clock);
            #1;
        end
        check_value("r handshakes", r_hs, ar_hs);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- icache_properties.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite read handshake rules, bound into prefetch_fill
// outstanding request tracked from the handshakes, not the FSM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_properties (
    input logic                 clock,
    input logic                 reset,
    input icache_pkg::br_task_t br_task,
    input logic                 ar_valid,
    input icache_pkg::axi_ar_t  ar,
    input logic                 ar_ready,
    input logic                 r_valid,
    input logic                 r_ready,
    input logic                 write_en,
    input logic                 alloc_en
);

    import icache_pkg::*;

    // high from the AR handshake until the R handshake
    logic outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (r_valid && r_ready) begin
            outstanding <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            outstanding <= 1'b1;
        end
    end

    // payload held under back-pressure
    ar_stable: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR payload changed while stalled");

    // one request at a time
    one_outstanding: assert property (@(posedge clock) disable iff (reset)
        outstanding |-> !ar_valid)
        else $error("AR raised while R still pending");

    idle_no_ready: assert property (@(posedge clock) disable iff (reset)
        !outstanding |-> !r_ready)
        else $error("r_ready high with no request outstanding");

    squash_no_write: assert property (@(posedge clock) disable iff (reset)
        br_task == BR_SQUASH |-> !write_en && !alloc_en)
        else $error("cache update in a squash cycle");

    // write-back only in the cycle after an R handshake
    write_after_r: assert property (@(posedge clock) disable iff (reset)
        write_en |-> $past(r_valid && r_ready))
        else $error("write_en without an R handshake one cycle before");

endmodule

bind prefetch_fill icache_properties props (
    .clock    (clock),
    .reset    (reset),
    .br_task  (br_task),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .write_en (write_en),
    .alloc_en (alloc_en)
);

//--- tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock, 4 ns period
// reset high for the first 10 rising edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

//--- icache_top.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch cache top, cache plus fill controller
// exposes the fetch port and an AXI4-Lite read master
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_top #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // fetch port
    input  icache_pkg::addr_t                             fetch_addr,
    input  icache_pkg::br_task_t                          br_task,
    output icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0] data_out,
    output logic [PREFETCH_DISTANCE-1:0]                  valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                  alloc_out,

    // AXI4-Lite read port
    output logic                                          ar_valid,
    output icache_pkg::axi_ar_t                           ar,
    input  logic                                          ar_ready,
    input  logic                                          r_valid,
    input  icache_pkg::axi_r_t                            r,
    output logic                                          r_ready
);

    import icache_pkg::*;

    // fill to cache
    logic       alloc_en;
    addr_t      alloc_addr;
    logic       write_en;
    addr_t      write_addr;
    mem_block_t write_data;

    icache #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) cache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .br_task    (br_task),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .alloc_out  (alloc_out)
    );

    prefetch_fill #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) fill (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .br_task    (br_task),
        .valid_out  (valid_out),
        .alloc_out  (alloc_out),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r          (r),
        .r_ready    (r_ready)
    );

endmodule

//--- prefetch_fill.sv
////////////////////////////////////////////////////////////////////////////
// fill controller, one AXI4-Lite read outstanding at a time
// picks the lowest lane that is neither hit nor allocated
// a squash during a request drops its response on return
// write_en pulses one cycle after the R handshake
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module prefetch_fill #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                            clock,
    input  logic                            reset,

    input  icache_pkg::addr_t               fetch_addr,
    input  icache_pkg::br_task_t            br_task,

    // lane status from the cache
    input  logic [PREFETCH_DISTANCE-1:0]    valid_out,
    input  logic [PREFETCH_DISTANCE-1:0]    alloc_out,

    // to the cache
    output logic                            alloc_en,
    output icache_pkg::addr_t               alloc_addr,
    output logic                            write_en,
    output icache_pkg::addr_t               write_addr,
    output icache_pkg::mem_block_t          write_data,

    // AXI4-Lite read master
    output logic                            ar_valid,
    output icache_pkg::axi_ar_t             ar,
    input  logic                            ar_ready,
    input  logic                            r_valid,
    input  icache_pkg::axi_r_t              r,
    output logic                            r_ready
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t     state;
    logic       squash;
    logic       issue;
    logic       r_fire;
    logic       pick_found;
    blk_num_t   fetch_blk;
    blk_num_t   pick_blk;

    // control
    logic       alloc_q;
    logic       stale;
    logic       wb_pending;
    // payload
    addr_t      req_addr;
    mem_block_t wb_data;

    assign squash    = (br_task == BR_SQUASH);
    assign fetch_blk = fetch_addr[ADDR_BITS-1:ICACHE_OFF_BITS];

    // priority search, lowest missing lane wins
    always_comb begin
        pick_found = 1'b0;
        pick_blk   = fetch_blk;
        for (int i = PREFETCH_DISTANCE - 1; i >= 0; i--) begin
            if (!valid_out[i] && !alloc_out[i]) begin
                pick_found = 1'b1;
                pick_blk   = fetch_blk + blk_num_t'(i);
            end
        end
    end

    assign issue  = (state == S_IDLE) && pick_found && !squash;
    assign r_fire = (state == S_DATA) && r_valid;

    ////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= S_IDLE;
            alloc_q    <= 1'b0;
            stale      <= 1'b0;
            wb_pending <= 1'b0;
        end else begin
            alloc_q    <= issue;
            wb_pending <= 1'b0;
            case (state)
                S_IDLE: if (issue) begin
                    state <= S_ADDR;
                    stale <= 1'b0;
                end
                S_ADDR: if (ar_ready) state <= S_DATA;
                // error or squashed responses never reach the array
                S_DATA: if (r_valid) begin
                    state      <= S_IDLE;
                    wb_pending <= !(stale || squash) && (r.resp == AXI_RESP_OKAY);
                end
                default: state <= S_IDLE;
            endcase
            if (squash && state != S_IDLE) begin
                stale <= 1'b1;
            end
        end
    end

    // request address and returned block
    always_ff @(posedge clock) begin
        if (issue) req_addr <= {pick_blk, {ICACHE_OFF_BITS{1'b0}}};
        if (r_fire) wb_data <= r.data;
    end

    ////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////

    // alloc rides along with the first AR cycle
    assign alloc_en   = alloc_q && !squash;
    assign alloc_addr = req_addr;
    assign ar_valid   = (state == S_ADDR);
    assign ar         = '{addr: req_addr, prot: AXI_PROT_INSN};
    assign r_ready    = (state == S_DATA);
    // req_addr only moves at the end of this cycle
    assign write_en   = wb_pending && !squash;
    assign write_addr = req_addr;
    assign write_data = wb_data;

endmodule

//--- icache.sv
////////////////////////////////////////////////////////////////////////////
// direct-mapped instruction cache, tag state and multi-lane lookup
// lane i looks at block (fetch block + i), wrapping modulo 2^13
// lookup is combinational, state changes on the next edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // fetch side
    input  icache_pkg::addr_t                             fetch_addr,
    input  icache_pkg::br_task_t                          br_task,

    // from the fill controller
    input  logic                                          alloc_en,
    input  icache_pkg::addr_t                             alloc_addr,
    input  logic                                          write_en,
    input  icache_pkg::addr_t                             write_addr,
    input  icache_pkg::mem_block_t                        write_data,

    // lanes out
    output icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0] data_out,
    output logic [PREFETCH_DISTANCE-1:0]                  valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                  alloc_out
);

    import icache_pkg::*;

    // one entry per line
    icache_tag_t [ICACHE_LINES-1:0] tags;

    blk_num_t                            fetch_blk;
    blk_num_t  [PREFETCH_DISTANCE-1:0]   lane_blk;
    line_idx_t [PREFETCH_DISTANCE-1:0]   lane_idx;
    tag_bits_t [PREFETCH_DISTANCE-1:0]   lane_tag;

    line_idx_t write_idx;
    tag_bits_t write_tag;
    line_idx_t alloc_idx;

    ////////////////////////////////////////////////////////////////////////
    // address split
    ////////////////////////////////////////////////////////////////////////

    assign fetch_blk              = fetch_addr[ADDR_BITS-1:ICACHE_OFF_BITS];
    assign {write_tag, write_idx} = write_addr[ADDR_BITS-1:ICACHE_OFF_BITS];
    // only the index of the alloc address matters
    assign alloc_idx              = alloc_addr[ICACHE_OFF_BITS +: ICACHE_LINE_BITS];

    // per-lane block number, wraps at the top of memory
    always_comb begin
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            lane_blk[i]                = fetch_blk + blk_num_t'(i);
            {lane_tag[i], lane_idx[i]} = lane_blk[i];
        end
    end

    // hit needs valid and a matching tag, alloc ignores the tag
    always_comb begin
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            valid_out[i] = tags[lane_idx[i]].valid && (tags[lane_idx[i]].tag == lane_tag[i]);
            alloc_out[i] = tags[lane_idx[i]].alloc;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // data array
    ////////////////////////////////////////////////////////////////////////

    mem_dp #(
        .WIDTH      ($bits(mem_block_t)),
        .DEPTH      (ICACHE_LINES),
        .READ_PORTS (PREFETCH_DISTANCE)
    ) data_mem (
        .clock (clock),
        .reset (reset),
        .we    (write_en),
        .waddr (write_idx),
        .wdata (write_data),
        .raddr (lane_idx),
        .rdata (data_out)
    );

    ////////////////////////////////////////////////////////////////////////
    // tag state
    ////////////////////////////////////////////////////////////////////////

    // fill controller keeps alloc_en and write_en low on a squash
    always_ff @(posedge clock) begin
        if (reset) begin
            tags <= '0;
        end else begin
            if (br_task == BR_SQUASH) begin
                for (int l = 0; l < ICACHE_LINES; l++) begin
                    tags[l].alloc <= 1'b0;
                end
            end
            if (alloc_en) begin
                tags[alloc_idx].alloc <= 1'b1;
            end
            // fill completes, line becomes a hit next cycle
            if (write_en) begin
                tags[write_idx] <= '{valid: 1'b1, alloc: 1'b0, tag: write_tag};
            end
        end
    end

endmodule

//--- mem_dp.sv
////////////////////////////////////////////////////////////////////////////
// register-array memory, one write port, READ_PORTS async read ports
// no write-to-read bypass, contents undefined until written
// writes are ignored while reset is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_dp #(
    parameter int WIDTH      = 64,
    parameter int DEPTH      = 32,
    parameter int READ_PORTS = 1,
    localparam int IDX_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                                   clock,
    input  logic                                   reset,

    // write port
    input  logic                                   we,
    input  logic [IDX_BITS-1:0]                    waddr,
    input  logic [WIDTH-1:0]                       wdata,

    // read ports
    input  logic [READ_PORTS-1:0][IDX_BITS-1:0]    raddr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]       rdata
);

    // storage, no reset on the array itself
    logic [WIDTH-1:0] mem [DEPTH];

    ////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (we && !reset) begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////

    // old data visible in the write cycle
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rdata[p] = mem[raddr[p]];
        end
    end

endmodule

//--- icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types and geometry for the instruction cache subsystem
// 16-bit byte addresses, 8-byte blocks, direct mapped, 32 lines
// only the AXI4-Lite read channels are modelled
////////////////////////////////////////////////////////////////////////////

package icache_pkg;

    // address split: | tag | index | offset |
    localparam int ADDR_BITS        = 16;
    localparam int ICACHE_OFF_BITS  = 3;
    localparam int ICACHE_LINE_BITS = 5;
    localparam int ICACHE_LINES     = 1 << ICACHE_LINE_BITS;
    localparam int ICACHE_BLK_BITS  = ADDR_BITS - ICACHE_OFF_BITS;
    localparam int ICACHE_TAG_BITS  = ADDR_BITS - ICACHE_OFF_BITS - ICACHE_LINE_BITS;

    typedef logic [ADDR_BITS-1:0]        addr_t;
    typedef logic [63:0]                 mem_block_t;
    // block number, address without the byte offset
    typedef logic [ICACHE_BLK_BITS-1:0]  blk_num_t;
    typedef logic [ICACHE_LINE_BITS-1:0] line_idx_t;
    typedef logic [ICACHE_TAG_BITS-1:0]  tag_bits_t;

    // per-line bookkeeping
    typedef struct packed {
        logic      valid;
        logic      alloc;
        tag_bits_t tag;
    } icache_tag_t;

    typedef enum logic {
        BR_NONE   = 1'b0,
        BR_SQUASH = 1'b1
    } br_task_t;

    ////////////////////////////////////////////////////////////////////////
    // AXI4-Lite read channels
    ////////////////////////////////////////////////////////////////////////

    // unprivileged, secure, instruction access
    localparam logic [2:0] AXI_PROT_INSN = 3'b100;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axi_ar_t;

    typedef struct packed {
        mem_block_t data;
        logic [1:0] resp;
    } axi_r_t;

endpackage
